/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_adc
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* adc_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adc_defines.svh"

module adc_ctrl (
    input  wire logic                      clock,
    input  wire logic                      rst_n,
    input  wire logic                      sample,
    input  wire logic                      cfg_write,
    input  wire logic                      cfg_addr,
    input  wire logic [`ADC_CFG_WIDTH-1:0] cfg_data,
    input  wire logic                      frame_done,
    input  wire logic                      emit_done,
    output adc_pkg::adc_cfg_t              cfg,
    output logic                           run,
    output logic                           emit_start,
    output logic                           ss,
    output logic                           busy
);
    import adc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_CONVERT = 2'd1,
        ST_EMIT    = 2'd2
    } state_t;

    state_t    state;
    cfg_word_u wr_word;

    // The write data is decoded through both register views at once
    assign wr_word = cfg_data;

    // Configuration registers, updated on the cycle after the write strobe
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg.enable     <= 1'b0;
            // A divider of one keeps the serial clock legal out of reset
            cfg.sclk_div   <= 8'd1;
            cfg.frame_bits <= 5'(`ADC_DATA_WIDTH);
            cfg.dest       <= '0;
        end else if (cfg_write) begin
            if (cfg_addr == `ADC_ADDR_CTRL) begin
                cfg.enable     <= wr_word.ctrl.enable;
                cfg.sclk_div   <= wr_word.ctrl.sclk_div;
                cfg.frame_bits <= wr_word.ctrl.frame_bits;
            end else begin
                // Slots beyond the channel count are dropped
                for (int ch = 0; ch < `ADC_N_CHANNELS; ch++) begin
                    cfg.dest[ch] <= wr_word.dest.slot[ch];
                end
            end
        end
    end

    // Frame sequencer
    // A sample only counts while idle and enabled, so pulses during a frame are lost
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            emit_start <= 1'b0;
        end else begin
            // Emission is kicked off in the first cycle with ss back high
            emit_start <= (state == ST_CONVERT) && frame_done;
            case (state)
                ST_IDLE: begin
                    if (sample && cfg.enable) begin
                        state <= ST_CONVERT;
                    end
                end
                ST_CONVERT: begin
                    if (frame_done) begin
                        state <= ST_EMIT;
                    end
                end
                ST_EMIT: begin
                    // The last word leaves in the same cycle as emit_done
                    if (emit_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // The serial clock generator runs for exactly the convert phase
    assign run  = (state == ST_CONVERT);
    // Chip select is low for the whole convert phase
    assign ss   = !run;
    assign busy = (state != ST_IDLE);

    // Chip select only drops out of idle when an enabled sample was seen
    a_ss_from_idle: assert property (@(posedge clock) disable iff (!rst_n)
        (state == ST_IDLE) ##1 !ss |-> $past(sample && cfg.enable));

    // A sample arriving during a frame never starts another conversion
    a_sample_busy: assert property (@(posedge clock) disable iff (!rst_n)
        busy && sample |=> !$rose(run));

endmodule

`default_nettype wire

/* adc_defines.svh */
`ifndef ADC_DEFINES_SVH
`define ADC_DEFINES_SVH

// Number of ADC channels sharing the chip select and serial clock
// The destination register has eight slots, so up to eight channels fit
`define ADC_N_CHANNELS 2

// Width of one sample word, right-aligned in the shift register
// Anything from 8 to 16 bits works with the datapath
`define ADC_DATA_WIDTH 12

// Width of the destination tag attached to each output word
`define ADC_DEST_WIDTH 4

// Number of destination slots packed into one 32-bit register write
`define ADC_DEST_SLOTS 8

// Width of the register write data bus
`define ADC_CFG_WIDTH 32

// Register map, selected by the single address bit
// Address 0 holds enable, clock divider and frame length
`define ADC_ADDR_CTRL 1'b0
// Address 1 holds one destination tag per channel slot
`define ADC_ADDR_DEST 1'b1

`endif

/* adc_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adc_defines.svh"

module adc_monitor #(
    parameter int FRAMES = 8
) (
    input  wire logic                      clock,
    input  wire logic                      rst_n,
    input  wire logic                      cfg_write,
    input  wire logic                      cfg_addr,
    input  wire logic [`ADC_CFG_WIDTH-1:0] cfg_data,
    input  wire logic                      sclk,
    input  wire logic                      ss,
    input  wire logic                      out_valid,
    input  wire adc_pkg::adc_word_t        out_word,
    input  wire logic                      busy,
    input  wire logic                      check_end,
    output int                             errors
);
    import adc_pkg::*;

    localparam int N = `ADC_N_CHANNELS;

    logic [`ADC_DATA_WIDTH-1:0]        frame_mem [FRAMES*N];
    logic [N-1:0][`ADC_DEST_WIDTH-1:0] exp_dest;
    logic                              exp_enable;
    int                                exp_bits;
    int                                word_count;
    int                                frame_count;
    int                                sclk_rises;
    logic                              ss_q;
    logic                              sclk_q;
    logic                              frame_open;
    logic                              exp_busy;
    cfg_word_u                         wr_word;
    adc_word_t                         exp_word;
    string                             name;

    // The words of frame f sit at N*f up to N*f+N-1, so word k expects entry k
    initial begin
        errors      = 0;
        word_count  = 0;
        frame_count = 0;
        sclk_rises  = 0;
        $readmemh("adc_testdata.txt", frame_mem);
    end

    // Register writes are decoded the same way the register map defines them
    assign wr_word = cfg_data;

    always @(posedge clock) begin
        if (!rst_n) begin
            // After reset the interface is disabled with no tags and a full-width frame
            exp_enable = 1'b0;
            exp_bits   = `ADC_DATA_WIDTH;
            exp_dest   = '0;
            ss_q       = 1'b1;
            sclk_q     = 1'b0;
            frame_open = 1'b0;
        end else begin
            // Busy covers the whole frame and the burst up to its last word
            exp_busy = !ss || frame_open;
            if (busy !== exp_busy) begin
                errors++;
                $display("mismatch busy after %0d frames: expected %b, actual %b",
                         frame_count, exp_busy, busy);
            end
            if (!ss) begin
                frame_open = 1'b1;
            end
            // A falling chip select opens a frame
            if (!ss && ss_q) begin
                frame_count++;
                sclk_rises = 0;
                if (!exp_enable) begin
                    errors++;
                    $display("chip select fell while the interface was disabled");
                end
            end
            if (!ss && sclk && !sclk_q) begin
                sclk_rises++;
            end
            // Every frame carries exactly frame_bits serial clocks
            if (ss && !ss_q && (sclk_rises != exp_bits)) begin
                errors++;
                $display("frame %0d had %0d serial clock rises, expected %0d",
                         frame_count - 1, sclk_rises, exp_bits);
            end
            // Serial clock idles low whenever chip select is high
            if (ss && sclk) begin
                errors++;
                $display("serial clock is high while chip select is high");
            end
            // Words come out channel by channel, in frame order
            if (out_valid) begin
                if (word_count >= FRAMES * N) begin
                    errors++;
                    $display("output word %h came after all expected words", out_word);
                end else begin
                    exp_word.dest = exp_dest[word_count % N];
                    exp_word.data = frame_mem[word_count];
                    name = $sformatf("frame %0d channel %0d", word_count / N, word_count % N);
                    if (out_word !== exp_word) begin
                        errors++;
                        $display("mismatch %s: expected %h, actual %h", name, exp_word, out_word);
                    end
                end
                // The last channel closes the frame
                if ((word_count % N) == N - 1) begin
                    frame_open = 1'b0;
                end
                word_count++;
            end
            // The configuration follows each write, starting with the next cycle
            if (cfg_write) begin
                if (cfg_addr == `ADC_ADDR_CTRL) begin
                    exp_enable = wr_word.ctrl.enable;
                    exp_bits   = int'(wr_word.ctrl.frame_bits);
                end else begin
                    // Nibble i of the destination word tags channel i
                    for (int ch = 0; ch < N; ch++) begin
                        exp_dest[ch] = cfg_data[ch*`ADC_DEST_WIDTH +: `ADC_DEST_WIDTH];
                    end
                end
            end
            // Extra frames or lost words only show up in the totals
            if (check_end) begin
                if (word_count != FRAMES * N) begin
                    errors++;
                    $display("saw %0d output words, expected %0d", word_count, FRAMES * N);
                end
                if (frame_count != FRAMES) begin
                    errors++;
                    $display("saw %0d frames, expected %0d", frame_count, FRAMES);
                end
            end
            ss_q   = ss;
            sclk_q = sclk;
        end
    end

endmodule

`default_nettype wire

/* adc_pkg.sv */
`default_nettype none

`include "adc_defines.svh"

package adc_pkg;

    // Control register layout as seen on the write data bus
    // Bit 0 is the enable, the clock divider sits right above it
    typedef struct packed {
        logic [17:0] reserved;
        logic [4:0]  frame_bits;
        logic [7:0]  sclk_div;
        logic        enable;
    } ctrl_word_t;

    // Destination register layout, slot 0 in the low nibble
    // Slot i tags the words coming from channel i
    typedef struct packed {
        logic [`ADC_DEST_SLOTS-1:0][`ADC_DEST_WIDTH-1:0] slot;
    } dest_word_t;

    // The same write data is read as one layout or the other
    // The register address decides which view applies
    typedef union packed {
        ctrl_word_t ctrl;
        dest_word_t dest;
    } cfg_word_u;

    // Configuration held by the control block and seen by the datapath
    // Only the destination slots of existing channels are kept
    typedef struct packed {
        logic                                            enable;
        logic [7:0]                                      sclk_div;
        logic [4:0]                                      frame_bits;
        logic [`ADC_N_CHANNELS-1:0][`ADC_DEST_WIDTH-1:0] dest;
    } adc_cfg_t;

    // One output word, the tag in the upper bits
    typedef struct packed {
        logic [`ADC_DEST_WIDTH-1:0] dest;
        logic [`ADC_DATA_WIDTH-1:0] data;
    } adc_word_t;

endpackage

`default_nettype wire

/* adc_sclk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_sclk_gen (
    input  wire logic               clock,
    input  wire logic               rst_n,
    input  wire logic               run,
    input  wire adc_pkg::adc_cfg_t  cfg,
    output logic                    sclk,
    output logic                    cap_strobe,
    output logic                    frame_done
);

    logic [7:0] half_cnt;
    logic [5:0] bit_cnt;
    logic [5:0] frame_len;
    logic       toggle;

    // A frame length field of zero stands for the full 32 clocks
    assign frame_len = (cfg.frame_bits == 5'd0) ? 6'd32 : {1'b0, cfg.frame_bits};

    // The serial clock flips at the end of each half period
    // Once all bits are in, the clock parks low until run drops
    assign toggle = run && (half_cnt == cfg.sclk_div - 8'd1) && (bit_cnt < frame_len);

    // A toggle while high is a falling edge, where the receivers sample
    assign cap_strobe = toggle && sclk;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt   <= '0;
            bit_cnt    <= '0;
            sclk       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // Raised in the cycle that sees the last falling edge
            frame_done <= cap_strobe && (bit_cnt == frame_len - 6'd1);
            if (!run) begin
                // Idle between frames, so the first rise comes sclk_div cycles after ss falls
                half_cnt <= '0;
                bit_cnt  <= '0;
                sclk     <= 1'b0;
            end else begin
                if (toggle) begin
                    half_cnt <= '0;
                    sclk     <= ~sclk;
                end else if (bit_cnt < frame_len) begin
                    half_cnt <= half_cnt + 8'd1;
                end
                if (cap_strobe) begin
                    bit_cnt <= bit_cnt + 6'd1;
                end
            end
        end
    end

    // A zero divider would wrap the half period counter
    a_div_nonzero: assert property (@(posedge clock) disable iff (!rst_n)
        run |-> (cfg.sclk_div != 8'd0));

endmodule

`default_nettype wire

/* adc_shift_rx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adc_defines.svh"

module adc_shift_rx (
    input  wire logic                       clock,
    input  wire logic                       rst_n,
    input  wire logic                       run,
    input  wire logic                       cap_strobe,
    input  wire logic                       miso_bit,
    output logic [`ADC_DATA_WIDTH-1:0]      sample_word
);

    logic run_q;
    logic frame_start;

    // Delayed copy of run to find the first cycle of a frame
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= run;
        end
    end

    // Rising edge of run, one cycle before any capture can happen
    assign frame_start = run && !run_q;

    // Data arrives MSB first and shifts in at the bottom
    // With a frame longer than the word, the oldest bits fall off the top
    always_ff @(posedge clock) begin
        if (frame_start) begin
            sample_word <= '0;
        end else if (cap_strobe) begin
            sample_word <= {sample_word[`ADC_DATA_WIDTH-2:0], miso_bit};
        end
    end

endmodule

`default_nettype wire

/* adc_stream_out.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adc_defines.svh"

module adc_stream_out (
    input  wire logic                                            clock,
    input  wire logic                                            rst_n,
    input  wire logic                                            emit_start,
    input  wire adc_pkg::adc_cfg_t                               cfg,
    input  wire logic [`ADC_N_CHANNELS-1:0][`ADC_DATA_WIDTH-1:0] words,
    output logic                                                 out_valid,
    output adc_pkg::adc_word_t                                   out_word,
    output logic                                                 emit_done
);

    localparam int N     = `ADC_N_CHANNELS;
    // A single channel still needs a one bit index
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0][`ADC_DATA_WIDTH-1:0] held;
    logic [IDX_W-1:0]                  idx;
    logic                              active;
    logic                              last;

    // Snapshot of every channel, so the receivers are free for the next frame
    always_ff @(posedge clock) begin
        if (emit_start) begin
            held <= words;
        end
    end

    assign last = (idx == IDX_W'(N - 1));

    // Channel index walks from 0 to N-1, one step per cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (emit_start) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            if (last) begin
                active <= 1'b0;
                idx    <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Each word takes the destination configured for its channel
    always_comb begin
        out_word.dest = cfg.dest[idx];
        out_word.data = held[idx];
    end

    assign out_valid = active;
    // Control sees the end of the burst together with the last word
    assign emit_done = active && last;

    // No burst is longer than one word per channel
    a_valid_burst: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid [*N] |=> !out_valid);

endmodule

`default_nettype wire

/* adc_testdata.txt */
// One conversion frame per line, in the order the frames are run
// Column 1 is the channel 0 sample, column 2 the channel 1 sample, 12-bit hex
fff 000
800 001
a5a 5a5
123 abc
7ff 800
0f0 f0f
3c3 c3c
555 aaa

/* project.f */
+incdir+.
adc_pkg.sv
adc_ctrl.sv
adc_sclk_gen.sv
adc_shift_rx.sv
adc_stream_out.sv
spi_adc_interface.sv
adc_monitor.sv
tb_spi_adc.sv

/* spi_adc_interface.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adc_defines.svh"

module spi_adc_interface (
    input  wire logic                      clock,
    input  wire logic                      rst_n,
    input  wire logic                      sample,
    input  wire logic [`ADC_N_CHANNELS-1:0] miso,
    input  wire logic                      cfg_write,
    input  wire logic                      cfg_addr,
    input  wire logic [`ADC_CFG_WIDTH-1:0] cfg_data,
    output logic                           sclk,
    output logic                           ss,
    output logic                           out_valid,
    output adc_pkg::adc_word_t             out_word,
    output logic                           busy
);
    import adc_pkg::*;

    adc_cfg_t cfg;
    logic     run;
    logic     emit_start;
    logic     frame_done;
    logic     emit_done;
    logic     cap_strobe;

    // One received word per channel, indexed by channel number
    logic [`ADC_N_CHANNELS-1:0][`ADC_DATA_WIDTH-1:0] words;

    // Register decode and the idle, convert and emit sequencer
    adc_ctrl u_ctrl (
        .clock      (clock),
        .rst_n      (rst_n),
        .sample     (sample),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .frame_done (frame_done),
        .emit_done  (emit_done),
        .cfg        (cfg),
        .run        (run),
        .emit_start (emit_start),
        .ss         (ss),
        .busy       (busy)
    );

    // Shared serial clock and the capture strobe for all receivers
    adc_sclk_gen u_sclk_gen (
        .clock      (clock),
        .rst_n      (rst_n),
        .run        (run),
        .cfg        (cfg),
        .sclk       (sclk),
        .cap_strobe (cap_strobe),
        .frame_done (frame_done)
    );

    // Every channel shifts in its own data line in parallel
    for (genvar ch = 0; ch < `ADC_N_CHANNELS; ch++) begin : g_rx
        adc_shift_rx u_rx (
            .clock       (clock),
            .rst_n       (rst_n),
            .run         (run),
            .cap_strobe  (cap_strobe),
            .miso_bit    (miso[ch]),
            .sample_word (words[ch])
        );
    end

    // Serializes the captured words into tagged output words
    adc_stream_out u_stream_out (
        .clock      (clock),
        .rst_n      (rst_n),
        .emit_start (emit_start),
        .cfg        (cfg),
        .words      (words),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .emit_done  (emit_done)
    );

endmodule

`default_nettype wire

/* tb_spi_adc.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adc_defines.svh"

module tb_spi_adc;
    import adc_pkg::*;

    localparam int N          = `ADC_N_CHANNELS;
    localparam int W          = `ADC_DATA_WIDTH;
    localparam int FRAMES     = 8;
    localparam int SCLK_DIV   = 2;
    localparam int FRAME_BITS = 12;
    // Each frame needs its serial phase, the burst and a short gap
    localparam int TIMEOUT    = FRAMES * (2 * SCLK_DIV * FRAME_BITS + 2 + N + 10) + 200;

    logic                      clock;
    logic                      rst_n;
    logic                      sample;
    logic [N-1:0]              miso;
    logic                      cfg_write;
    logic                      cfg_addr;
    logic [`ADC_CFG_WIDTH-1:0] cfg_data;
    logic                      sclk;
    logic                      ss;
    logic                      out_valid;
    adc_word_t                 out_word;
    logic                      busy;
    logic                      check_end;
    int                        mon_errors;
    logic [W-1:0]              frame_mem [FRAMES*N];
    logic [N-1:0][W-1:0]       adc_sr;
    logic                      sclk_q;
    int                        cur_frame;
    int                        cycle_count = 0;
    integer                    seed;

    spi_adc_interface DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .sample    (sample),
        .miso      (miso),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .sclk      (sclk),
        .ss        (ss),
        .out_valid (out_valid),
        .out_word  (out_word),
        .busy      (busy)
    );

    adc_monitor #(.FRAMES(FRAMES)) u_monitor (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .sclk      (sclk),
        .ss        (ss),
        .out_valid (out_valid),
        .out_word  (out_word),
        .busy      (busy),
        .check_end (check_end),
        .errors    (mon_errors)
    );

    always #50 clock = ~clock;

    // Each ADC model loads its sample while deselected and puts out the next bit
    // MSB first one clock after every serial clock rise
    always @(posedge clock) begin
        sclk_q <= sclk;
        for (int ch = 0; ch < N; ch++) begin
            if (ss) begin
                adc_sr[ch] <= frame_mem[cur_frame * N + ch];
            end else if (sclk && !sclk_q) begin
                miso[ch]   <= adc_sr[ch][W-1];
                adc_sr[ch] <= adc_sr[ch] << 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout after %0d cycles, the frames did not complete", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Control register value with the fixed divider and frame length
    function automatic logic [31:0] ctrl_value(input logic en);
        ctrl_word_t w;
        w            = '0;
        w.enable     = en;
        w.sclk_div   = 8'(SCLK_DIV);
        w.frame_bits = 5'(FRAME_BITS);
        return w;
    endfunction

    task automatic write_reg(input logic addr, input logic [31:0] data);
        @(posedge clock);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_data  <= data;
        @(posedge clock);
        cfg_write <= 1'b0;
    endtask

    task automatic pulse_sample();
        @(posedge clock);
        sample <= 1'b1;
        @(posedge clock);
        sample <= 1'b0;
    endtask

    // One accepted frame, optionally with a stray sample while busy
    task automatic run_frame(input int f, input bit poke_busy);
        int gap;
        cur_frame = f;
        pulse_sample();
        while (!busy) @(posedge clock);
        if (poke_busy) begin
            repeat (10) @(posedge clock);
            pulse_sample();
        end
        while (busy) @(posedge clock);
        gap = $random(seed) & 3;
        repeat (gap) @(posedge clock);
    endtask

    initial begin
        clock     = 1'b0;
        rst_n     = 1'b0;
        sample    = 1'b0;
        miso      = '0;
        cfg_write = 1'b0;
        cfg_addr  = 1'b0;
        cfg_data  = '0;
        check_end = 1'b0;
        cur_frame = 0;
        seed      = 32'h0f37_7784;
        $readmemh("adc_testdata.txt", frame_mem);
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        // Channel 0 is tagged 7 and channel 1 is tagged 5
        write_reg(`ADC_ADDR_CTRL, ctrl_value(1'b1));
        write_reg(`ADC_ADDR_DEST, 32'h0000_0057);
        for (int f = 0; f < FRAMES; f++) begin
            if (f == 2) begin
                // Samples while disabled must start nothing
                write_reg(`ADC_ADDR_CTRL, ctrl_value(1'b0));
                repeat (3) begin
                    pulse_sample();
                    repeat (4) @(posedge clock);
                end
                write_reg(`ADC_ADDR_CTRL, ctrl_value(1'b1));
            end
            if (f == FRAMES / 2) begin
                write_reg(`ADC_ADDR_DEST, 32'h0000_0093);
            end
            run_frame(f, (f % 2) == 1);
        end
        repeat (4) @(posedge clock);
        check_end <= 1'b1;
        @(posedge clock);
        check_end <= 1'b0;
        repeat (2) @(posedge clock);
        $display("%0d frames run, %0d errors", FRAMES, mon_errors);
        if (mon_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
